/* design/wb8_pkg.sv */
`default_nettype none

package wb8_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 8;

    // 1 KiB of block RAM
    localparam int RAM_AW = 10;

    // memory map, top nibble of the address picks memory or I/O
    localparam logic [3:0] IO_REGION = 4'hF;
    // device nibble inside I/O space, anything else lands on the LEDs
    localparam logic [3:0] DEV_SPI = 4'h0;

    // SPI register offsets in adr[1:0]
    localparam logic [1:0] SPI_REG_DATA   = 2'd0;
    localparam logic [1:0] SPI_REG_STATUS = 2'd1;
    localparam logic [1:0] SPI_REG_CS     = 2'd2;
    localparam logic [1:0] SPI_REG_DIV    = 2'd3;

    // memory view of an address
    typedef struct packed {
        logic [ADDR_W-RAM_AW-1:0] unused;
        logic [RAM_AW-1:0]        index;
    } wb8_mem_addr_t;

    // I/O view of an address
    typedef struct packed {
        logic [3:0]  region;
        logic [3:0]  device;
        logic [23:0] offset;
    } wb8_io_addr_t;

    // one bus address, decoded either way
    typedef union packed {
        wb8_mem_addr_t mem;
        wb8_io_addr_t  io;
    } wb8_addr_u;

endpackage

`default_nettype wire

/* design/wb8_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module wb8_decode (
    input  wire logic                        cyc_i,
    input  wire logic                        stb_i,
    input  wire logic [wb8_pkg::ADDR_W-1:0]  adr_i,

    // RAM response
    input  wire logic [wb8_pkg::DATA_W-1:0]  ram_dat_i,
    input  wire logic                        ram_ack_i,

    // LED register response
    input  wire logic [wb8_pkg::DATA_W-1:0]  leds_dat_i,
    input  wire logic                        leds_ack_i,

    // SPI master response
    input  wire logic [wb8_pkg::DATA_W-1:0]  spi_dat_i,
    input  wire logic                        spi_ack_i,

    output logic                             ram_stb_o,
    output logic                             leds_stb_o,
    output logic                             spi_stb_o,
    output logic [wb8_pkg::DATA_W-1:0]       dat_o,
    output logic                             ack_o
);

    wb8_pkg::wb8_addr_u adr_u;
    logic               req;
    logic               sel_io;
    logic               sel_spi;
    logic               sel_leds;
    logic               sel_ram;

    assign adr_u = adr_i;
    assign req   = cyc_i & stb_i;

    // 0xFxxxxxxx is I/O, everything else is RAM
    assign sel_io   = (adr_u.io.region == wb8_pkg::IO_REGION);
    assign sel_spi  = sel_io & (adr_u.io.device == wb8_pkg::DEV_SPI);
    assign sel_leds = sel_io & ~sel_spi;
    assign sel_ram  = ~sel_io;

    // only the selected target sees the strobe
    assign ram_stb_o  = req & sel_ram;
    assign leds_stb_o = req & sel_leds;
    assign spi_stb_o  = req & sel_spi;

    // response mux back to the master
    always_comb begin
        if (sel_spi) begin
            dat_o = spi_dat_i;
            ack_o = spi_ack_i;
        end else if (sel_leds) begin
            dat_o = leds_dat_i;
            ack_o = leds_ack_i;
        end else begin
            dat_o = ram_dat_i;
            ack_o = ram_ack_i;
        end
    end

endmodule

`default_nettype wire

/* design/ram1k_wb8.sv */
`timescale 1ns/1ps
`default_nettype none

module ram1k_wb8 (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,
    input  wire logic                        stb_i,
    input  wire logic                        we_i,
    input  wire logic [wb8_pkg::RAM_AW-1:0]  adr_i,
    input  wire logic [wb8_pkg::DATA_W-1:0]  dat_i,
    output logic [wb8_pkg::DATA_W-1:0]       dat_o,
    output logic                             ack_o
);

    logic [wb8_pkg::DATA_W-1:0] mem_q [0:(1 << wb8_pkg::RAM_AW)-1];
    logic [wb8_pkg::DATA_W-1:0] dat_q;
    logic                       ack_q;
    logic                       access;

    // new access when strobed and not already acking
    assign access = stb_i & ~ack_q;

    // one ack cycle per access
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // block RAM with registered read, write lands with the ack edge
    always_ff @(posedge clk) begin
        if (access) begin
            if (we_i) begin
                mem_q[adr_i] <= dat_i;
            end
            dat_q <= mem_q[adr_i];
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;

endmodule

`default_nettype wire

/* design/leds_wb8.sv */
`timescale 1ns/1ps
`default_nettype none

module leds_wb8 (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,
    input  wire logic                        stb_i,
    input  wire logic                        we_i,
    input  wire logic [wb8_pkg::DATA_W-1:0]  dat_i,
    output logic [wb8_pkg::DATA_W-1:0]       dat_o,
    output logic                             ack_o,
    output logic [wb8_pkg::DATA_W-1:0]       leds_o
);

    logic [wb8_pkg::DATA_W-1:0] leds_q;
    logic                       ack_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            leds_q <= '0;
        end else begin
            ack_q <= stb_i & ~ack_q;
            // load on the edge that raises ack
            if (stb_i && we_i && !ack_q) begin
                leds_q <= dat_i;
            end
        end
    end

    // readback of the current LED state
    assign dat_o  = leds_q;
    assign ack_o  = ack_q;
    assign leds_o = leds_q;

endmodule

`default_nettype wire

/* design/spi_wb8.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_wb8 (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,
    input  wire logic                        stb_i,
    input  wire logic                        we_i,
    input  wire logic [1:0]                  adr_i,
    input  wire logic [wb8_pkg::DATA_W-1:0]  dat_i,
    output logic [wb8_pkg::DATA_W-1:0]       dat_o,
    output logic                             ack_o,

    // SPI pins, mode 0
    output logic                             spi_clk_o,
    output logic                             spi_mosi_o,
    output logic                             spi_cs_o,
    input  wire logic                        spi_miso_i
);

    logic                       ack_q;
    logic [wb8_pkg::DATA_W-1:0] dat_q;
    logic                       cs_q;
    logic [wb8_pkg::DATA_W-1:0] div_q;

    // shift engine state
    logic                       busy_q;
    logic                       sclk_q;
    logic [wb8_pkg::DATA_W-1:0] div_cnt_q;
    logic [2:0]                 bit_cnt_q;
    logic [wb8_pkg::DATA_W-1:0] shift_q;
    logic                       miso_q;
    logic [wb8_pkg::DATA_W-1:0] rx_q;

    logic                       access;
    logic                       wr_access;
    logic                       start;
    logic                       half_done;
    logic                       sclk_rise;
    logic                       sclk_fall;
    logic                       last_fall;

    assign access    = stb_i & ~ack_q;
    assign wr_access = access & we_i;

    // a DATA write only starts a transfer when idle
    assign start     = wr_access & (adr_i == wb8_pkg::SPI_REG_DATA) & ~busy_q;

    // each half period is div+1 clocks
    assign half_done = (div_cnt_q == div_q);
    assign sclk_rise = busy_q & half_done & ~sclk_q;
    assign sclk_fall = busy_q & half_done & sclk_q;
    assign last_fall = sclk_fall & (bit_cnt_q == 3'd7);

    // bus side registers
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            cs_q  <= 1'b1;
            div_q <= '0;
        end else begin
            ack_q <= access;
            if (wr_access && adr_i == wb8_pkg::SPI_REG_CS) begin
                cs_q <= dat_i[0];
            end
            if (wr_access && adr_i == wb8_pkg::SPI_REG_DIV) begin
                div_q <= dat_i;
            end
        end
    end

    // read data captured with the access
    always_ff @(posedge clk) begin
        if (access) begin
            case (adr_i)
                wb8_pkg::SPI_REG_DATA:   dat_q <= rx_q;
                wb8_pkg::SPI_REG_STATUS: dat_q <= {7'd0, busy_q};
                wb8_pkg::SPI_REG_CS:     dat_q <= {7'd0, cs_q};
                default:                 dat_q <= div_q;
            endcase
        end
    end

    // clock divider, bit counter and shifter
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            sclk_q    <= 1'b0;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            shift_q   <= '0;
        end else if (start) begin
            // first mosi bit is out before the first rising edge
            busy_q    <= 1'b1;
            sclk_q    <= 1'b0;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            shift_q   <= dat_i;
        end else if (busy_q) begin
            if (half_done) begin
                div_cnt_q <= '0;
                sclk_q    <= ~sclk_q;
            end else begin
                div_cnt_q <= div_cnt_q + 1'b1;
            end
            // falling edge moves the next bit onto mosi
            if (sclk_fall) begin
                shift_q   <= {shift_q[wb8_pkg::DATA_W-2:0], miso_q};
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
            // done after the 8th low-going edge
            if (last_fall) begin
                busy_q <= 1'b0;
            end
        end
    end

    // miso sampled as sclk goes high, received byte kept for DATA reads
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            miso_q <= spi_miso_i;
        end
        if (last_fall) begin
            rx_q <= {shift_q[wb8_pkg::DATA_W-2:0], miso_q};
        end
    end

    assign dat_o      = dat_q;
    assign ack_o      = ack_q;
    assign spi_clk_o  = sclk_q;
    assign spi_mosi_o = shift_q[wb8_pkg::DATA_W-1];
    assign spi_cs_o   = cs_q;

endmodule

`default_nettype wire

/* design/wb8_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module wb8_periph_top (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,

    // bus master side
    input  wire logic                        cyc_i,
    input  wire logic                        stb_i,
    input  wire logic                        we_i,
    input  wire logic [wb8_pkg::ADDR_W-1:0]  adr_i,
    input  wire logic [wb8_pkg::DATA_W-1:0]  dat_i,
    output logic [wb8_pkg::DATA_W-1:0]       dat_o,
    output logic                             ack_o,

    output logic [wb8_pkg::DATA_W-1:0]       leds_o,

    // SPI port
    input  wire logic                        spi_miso_i,
    output logic                             spi_clk_o,
    output logic                             spi_mosi_o,
    output logic                             spi_cs_o
);

    wb8_pkg::wb8_addr_u         adr_u;

    logic                       ram_stb;
    logic [wb8_pkg::DATA_W-1:0] ram_dat;
    logic                       ram_ack;

    logic                       leds_stb;
    logic [wb8_pkg::DATA_W-1:0] leds_dat;
    logic                       leds_ack;

    logic                       spi_stb;
    logic [wb8_pkg::DATA_W-1:0] spi_dat;
    logic                       spi_ack;

    assign adr_u = adr_i;

    wb8_decode i_wb8_decode (
        .cyc_i      (cyc_i),
        .stb_i      (stb_i),
        .adr_i      (adr_i),
        .ram_dat_i  (ram_dat),
        .ram_ack_i  (ram_ack),
        .leds_dat_i (leds_dat),
        .leds_ack_i (leds_ack),
        .spi_dat_i  (spi_dat),
        .spi_ack_i  (spi_ack),
        .ram_stb_o  (ram_stb),
        .leds_stb_o (leds_stb),
        .spi_stb_o  (spi_stb),
        .dat_o      (dat_o),
        .ack_o      (ack_o)
    );

    // upper address bits alias within RAM space
    ram1k_wb8 i_ram1k_wb8 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (ram_stb),
        .we_i    (we_i),
        .adr_i   (adr_u.mem.index),
        .dat_i   (dat_i),
        .dat_o   (ram_dat),
        .ack_o   (ram_ack)
    );

    leds_wb8 i_leds_wb8 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (leds_stb),
        .we_i    (we_i),
        .dat_i   (dat_i),
        .dat_o   (leds_dat),
        .ack_o   (leds_ack),
        .leds_o  (leds_o)
    );

    // register select from the low offset bits
    spi_wb8 i_spi_wb8 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stb_i      (spi_stb),
        .we_i       (we_i),
        .adr_i      (adr_u.io.offset[1:0]),
        .dat_i      (dat_i),
        .dat_o      (spi_dat),
        .ack_o      (spi_ack),
        .spi_clk_o  (spi_clk_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_cs_o   (spi_cs_o),
        .spi_miso_i (spi_miso_i)
    );

endmodule

`default_nettype wire

/* test/wb8_periph_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module wb8_periph_tb;

    localparam int SEED         = 32'h4e17;
    localparam int RESET_CYCLES = 10;
    localparam int N_RAM        = 32;
    localparam int N_LED        = 4;
    localparam int N_SPI        = 4;
    localparam int SPI_DIV      = 2;
    localparam int ACK_LIMIT    = 4;
    localparam int POLL_LIMIT   = 32;
    localparam int N_ACCESS     = 3 * N_RAM + 2 * N_LED + 5 + N_SPI * 5;
    localparam int WATCHDOG     = N_ACCESS * 4 + N_SPI * 8 * 2 * (SPI_DIV + 1) * 2 + 1000;

    localparam logic [31:0] SPI_BASE   = {wb8_pkg::IO_REGION, wb8_pkg::DEV_SPI, 24'h0};
    localparam logic [31:0] SPI_DATA   = SPI_BASE | wb8_pkg::SPI_REG_DATA;
    localparam logic [31:0] SPI_STATUS = SPI_BASE | wb8_pkg::SPI_REG_STATUS;
    localparam logic [31:0] SPI_CS     = SPI_BASE | wb8_pkg::SPI_REG_CS;
    localparam logic [31:0] SPI_DIVREG = SPI_BASE | wb8_pkg::SPI_REG_DIV;

    logic        clk;
    logic        rst_n_i;
    logic        cyc_i;
    logic        stb_i;
    logic        we_i;
    logic [31:0] adr_i;
    logic [7:0]  dat_i;
    logic [7:0]  dat_o;
    logic        ack_o;
    logic [7:0]  leds_o;
    logic        spi_miso_i;
    logic        spi_clk_o;
    logic        spi_mosi_o;
    logic        spi_cs_o;

    int          bus_errs;
    int          value_errs;
    int          timing_errs;
    logic [7:0]  ref_mem [0:1023];
    int          ram_idx [$];

    // SPI slave model state
    logic [7:0]  slave_byte;
    logic [7:0]  mosi_byte;
    logic        sclk_prev;
    logic        xfer_active;
    logic        cs_exp;
    int          phase_cnt;
    int          rise_cnt;
    int          fall_cnt;

    wb8_periph_top i_wb8_periph_top (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cyc_i      (cyc_i),
        .stb_i      (stb_i),
        .we_i       (we_i),
        .adr_i      (adr_i),
        .dat_i      (dat_i),
        .dat_o      (dat_o),
        .ack_o      (ack_o),
        .leds_o     (leds_o),
        .spi_miso_i (spi_miso_i),
        .spi_clk_o  (spi_clk_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_cs_o   (spi_cs_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ack one cycle after the strobe rises, and for one cycle only
    assert property (@(posedge clk) disable iff (!rst_n_i) $rose(stb_i) |=> ack_o)
        else begin
            $display("Fail at %0t ns: ack_o expected 1, got 0", $time);
            bus_errs++;
        end
    assert property (@(posedge clk) disable iff (!rst_n_i) ack_o |=> !ack_o)
        else begin
            $display("Fail at %0t ns: ack_o expected 0, got 1", $time);
            bus_errs++;
        end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_idle_outputs();
        check_value("ack_o", 0, ack_o);
        check_value("leds_o", 0, leds_o);
        check_value("spi_clk_o", 0, spi_clk_o);
        check_value("spi_cs_o", 1, spi_cs_o);
    endtask

    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [7:0] wdat, output logic [7:0] rdat);
        int waited;
        @(negedge clk);
        cyc_i = 1'b1;
        stb_i = 1'b1;
        we_i  = we;
        adr_i = adr;
        dat_i = wdat;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack_o && waited < ACK_LIMIT);
        assert (ack_o) else begin
            $display("no ack from the DUT for the access at address 0x%08h", adr);
            bus_errs++;
        end
        rdat  = dat_o;
        // address and we stay put until the next access
        cyc_i = 1'b0;
        stb_i = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [7:0] wdat);
        logic [7:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [7:0] rdat);
        bus_access(1'b0, adr, 8'h00, rdat);
    endtask

    // random RAM alias of a byte index, region never IO_REGION
    function automatic logic [31:0] ram_addr(input int idx);
        logic [9:0] low;
        logic [3:0] region;
        low    = idx;
        region = $urandom % 15;
        return {region, 18'($urandom), low};
    endfunction

    task automatic spi_transfer(input logic write_while_busy);
        logic [7:0] tx;
        logic [7:0] rx;
        logic [7:0] status;
        int         polls;
        tx         = $urandom;
        slave_byte = $urandom;
        spi_miso_i = slave_byte[7];
        bus_write(SPI_DATA, tx);
        bus_read(SPI_STATUS, status);
        check_value("dat_o (spi status busy)", 1, status);
        if (write_while_busy) begin
            bus_write(SPI_DATA, ~tx);
        end
        polls = 0;
        do begin
            bus_read(SPI_STATUS, status);
            polls++;
        end while (status[0] && polls < POLL_LIMIT);
        check_value("dat_o (spi status idle)", 0, status);
        check_value("spi_clk_o rising edges", 8, rise_cnt);
        check_value("spi_mosi_o byte", tx, mosi_byte);
        bus_read(SPI_DATA, rx);
        check_value("dat_o (spi rx data)", slave_byte, rx);
    endtask

    // SPI slave and clock monitor, sampled on the falling clk edge
    always @(negedge clk) begin
        if (!rst_n_i) begin
            xfer_active = 1'b0;
            sclk_prev   = 1'b0;
        end else if (!xfer_active) begin
            check_value("spi_clk_o while idle", 0, spi_clk_o);
            if (ack_o && we_i && adr_i == SPI_DATA) begin
                xfer_active = 1'b1;
                phase_cnt   = 0;
                rise_cnt    = 0;
                fall_cnt    = 0;
                mosi_byte   = '0;
            end
            sclk_prev = spi_clk_o;
        end else begin
            phase_cnt++;
            if (spi_clk_o !== sclk_prev) begin
                assert (phase_cnt == SPI_DIV + 1) else begin
                    $display("Fail at %0t ns: spi_clk_o phase expected %0d cycles, got %0d",
                             $time, SPI_DIV + 1, phase_cnt);
                    timing_errs++;
                end
                phase_cnt = 0;
                if (spi_clk_o) begin
                    mosi_byte = {mosi_byte[6:0], spi_mosi_o};
                    rise_cnt++;
                    check_value("spi_cs_o during transfer", cs_exp, spi_cs_o);
                end else begin
                    fall_cnt++;
                    if (fall_cnt < 8) begin
                        spi_miso_i = slave_byte[7 - fall_cnt];
                    end else begin
                        xfer_active = 1'b0;
                    end
                end
            end
            sclk_prev = spi_clk_o;
        end
    end

    task automatic print_error_counts();
        $display("errors: bus %0d, value %0d, timing %0d", bus_errs, value_errs, timing_errs);
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
        print_error_counts();
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] adr;
        logic [7:0]  wdat;
        logic [7:0]  rdat;
        int          idx;
        void'($urandom(SEED));
        bus_errs    = 0;
        value_errs  = 0;
        timing_errs = 0;
        cs_exp      = 1'b1;
        rst_n_i     = 1'b0;
        cyc_i       = 1'b0;
        stb_i       = 1'b0;
        we_i        = 1'b0;
        adr_i       = '0;
        dat_i       = '0;
        spi_miso_i  = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst_n_i = 1'b1;
        @(negedge clk);
        check_idle_outputs();

        // RAM writes, then reads through other aliases
        for (int i = 0; i < N_RAM; i++) begin
            idx  = $urandom % 1024;
            wdat = $urandom;
            bus_write(ram_addr(idx), wdat);
            ref_mem[idx] = wdat;
            ram_idx.push_back(idx);
        end
        foreach (ram_idx[i]) begin
            bus_read(ram_addr(ram_idx[i]), rdat);
            check_value("dat_o (ram read)", ref_mem[ram_idx[i]], rdat);
        end

        // any non-SPI device in I/O space is the LED register
        for (int i = 0; i < N_LED; i++) begin
            adr  = {wb8_pkg::IO_REGION, 4'(1 + $urandom % 15), 24'($urandom)};
            wdat = $urandom;
            bus_write(adr, wdat);
            check_value("leds_o", wdat, leds_o);
            bus_read(adr, rdat);
            check_value("dat_o (leds read)", wdat, rdat);
        end
        foreach (ram_idx[i]) begin
            bus_read(ram_addr(ram_idx[i]), rdat);
            check_value("dat_o (ram after leds)", ref_mem[ram_idx[i]], rdat);
        end

        bus_write(SPI_DIVREG, SPI_DIV);
        bus_read(SPI_DIVREG, rdat);
        check_value("dat_o (spi div)", SPI_DIV, rdat);
        bus_write(SPI_CS, 8'h00);
        cs_exp = 1'b0;
        check_value("spi_cs_o", cs_exp, spi_cs_o);
        for (int i = 0; i < N_SPI; i++) begin
            spi_transfer(i % 2 == 1);
        end
        bus_write(SPI_CS, 8'h01);
        cs_exp = 1'b1;
        check_value("spi_cs_o", cs_exp, spi_cs_o);

        @(negedge clk);
        print_error_counts();
        if (bus_errs + value_errs + timing_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* wb8_periph.f */
design/wb8_pkg.sv
design/wb8_decode.sv
design/ram1k_wb8.sv
design/leds_wb8.sv
design/spi_wb8.sv
design/wb8_periph_top.sv
test/wb8_periph_tb.sv

/* Bender.yml */
package:
  name: wb8_periph

sources:
  - files:
      - design/wb8_pkg.sv
      - design/wb8_decode.sv
      - design/ram1k_wb8.sv
      - design/leds_wb8.sv
      - design/spi_wb8.sv
      - design/wb8_periph_top.sv
  - target: test
    files:
      - test/wb8_periph_tb.sv
